/* hw/irq_pkg.sv */
// Interrupt source and channel definitions, imported by the latch, arbiter, top and testbench
`default_nettype none

package irq_pkg;

    // Sources per channel, one strobe bit each
    localparam int NUM_SOURCES = 8;

    // Channels sharing the vector table
    localparam int NUM_CHANNELS = 2;

    // One bit per source
    typedef logic [NUM_SOURCES-1:0] irq_mask_t;

    // Source number within a channel
    typedef logic [$clog2(NUM_SOURCES)-1:0] irq_id_t;

    // Channel number
    typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_t;

endpackage

`default_nettype wire

/* hw/table_pkg.sv */
// Vector table types and reset layout, imported by the table, queue, arbiter and testbench
`default_nettype none

package table_pkg;

    localparam int TABLE_ENTRIES = 16;
    localparam logic [31:0] VECTOR_BASE = 32'h3000_0000;
    localparam int VECTOR_STRIDE_SHIFT = 3;

    // Handler address for one interrupt
    typedef logic [31:0] vector_t;

    // Channel in the top bit, source number below
    typedef logic [$clog2(TABLE_ENTRIES)-1:0] table_index_t;

    // Reset contents of one entry: base plus index times stride
    function automatic vector_t default_vector(input table_index_t idx);
        return VECTOR_BASE + (vector_t'(idx) << VECTOR_STRIDE_SHIFT);
    endfunction

endpackage

`default_nettype wire

/* hw/irq_latch.sv */
// Per-channel pending register that issues one vector lookup at a time, lowest source first
`timescale 1ns/1ps
`default_nettype none

module irq_latch (
    input  wire                clk,
    input  wire                rst,
    input  irq_pkg::irq_mask_t irq,
    input  wire                grant,
    input  wire                lookup_done,
    input  wire                room,
    output logic               lookup_req,
    output irq_pkg::irq_id_t   lookup_id
);
    import irq_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } latch_state_t;

    latch_state_t state;
    irq_mask_t    pending_q;
    irq_mask_t    clear_mask;

    // Lowest pending source wins, so scan downwards and keep the last hit
    always_comb begin
        lookup_id = '0;
        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                lookup_id = irq_id_t'(i);
            end
        end
    end

    // No new request while a lookup is in flight or the queue is full
    assign lookup_req = (state != ST_WAIT) && (|pending_q) && room;

    // Bit handed to the arbiter this cycle
    assign clear_mask = grant ? (irq_mask_t'(1) << lookup_id) : '0;

    // Strobes merge into pending bits; a re-strobe on the granted bit keeps it set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clear_mask) | irq;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Grant may come in the first request cycle
                    if (lookup_req) begin
                        state <= grant ? ST_WAIT : ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (grant) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (lookup_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Arbiter only returns a result for a lookup this latch has issued
    a_done_only_when_waiting: assert property (
        @(posedge clk) disable iff (rst) lookup_done |-> state == ST_WAIT
    ) else $error("lookup_done arrived with no lookup outstanding");

endmodule

`default_nettype wire

/* hw/table_arbiter.sv */
// Round-robin arbiter for the shared table read port, routing each result back to its channel
`timescale 1ns/1ps
`default_nettype none

module table_arbiter (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req_a,
    input  irq_pkg::irq_id_t        id_a,
    input  wire                     req_b,
    input  irq_pkg::irq_id_t        id_b,
    output logic                    grant_a,
    output logic                    grant_b,
    output logic                    rd_en,
    output table_pkg::table_index_t rd_index,
    output logic                    done_a,
    output logic                    done_b
);
    import irq_pkg::*;
    import table_pkg::*;

    chan_t   last_chan;
    chan_t   win_chan;
    irq_id_t win_id;
    logic    done_valid;
    chan_t   done_chan;

    // On a tie the channel that lost last time goes first
    always_comb begin
        if (req_a && req_b) begin
            win_chan = ~last_chan;
        end else if (req_b) begin
            win_chan = chan_t'(1);
        end else begin
            win_chan = chan_t'(0);
        end
    end

    assign rd_en   = req_a || req_b;
    assign grant_a = rd_en && (win_chan == chan_t'(0));
    assign grant_b = rd_en && (win_chan == chan_t'(1));
    assign win_id  = grant_b ? id_b : id_a;

    // Entry number is channel then source
    assign rd_index = {win_chan, win_id};

    // Remember the winner and follow the table read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_chan  <= chan_t'(1);
            done_valid <= 1'b0;
            done_chan  <= chan_t'(0);
        end else begin
            done_valid <= rd_en;
            if (rd_en) begin
                last_chan <= win_chan;
                done_chan <= win_chan;
            end
        end
    end

    assign done_a = done_valid && (done_chan == chan_t'(0));
    assign done_b = done_valid && (done_chan == chan_t'(1));

    // A channel that loses a tie is served next, as the winner then waits for its result
    a_loser_served_next_a: assert property (
        @(posedge clk) disable iff (rst) req_a && !grant_a |=> grant_a
    ) else $error("channel A request not granted after losing a tie");

    a_loser_served_next_b: assert property (
        @(posedge clk) disable iff (rst) req_b && !grant_b |=> grant_b
    ) else $error("channel B request not granted after losing a tie");

endmodule

`default_nettype wire

/* hw/vector_table.sv */
// Writable 16-entry vector table with one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

module vector_table (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     we,
    input  table_pkg::table_index_t wr_index,
    input  table_pkg::vector_t      wr_vector,
    input  wire                     rd_en,
    input  table_pkg::table_index_t rd_index,
    output table_pkg::vector_t      rd_vector
);
    import table_pkg::*;

    vector_t mem [TABLE_ENTRIES];

    // Reset restores the base-plus-stride layout
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                mem[i] <= default_vector(table_index_t'(i));
            end
        end else if (we) begin
            mem[wr_index] <= wr_vector;
        end
    end

    // Read samples the array before this edge's write, so a colliding read sees old data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_vector <= '0;
        end else if (rd_en) begin
            rd_vector <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* hw/vector_queue.sv */
// Per-channel vector FIFO showing its head and a pending flag until acknowledged
`timescale 1ns/1ps
`default_nettype none

module vector_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                push,
    input  table_pkg::vector_t push_vector,
    input  wire                ack,
    output table_pkg::vector_t head_vector,
    output logic               pending,
    output logic               room
);
    import table_pkg::*;

    // Depth is a power of two; the extra pointer bit tells full from empty
    localparam int ADDR_W = $clog2(QUEUE_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    vector_t          mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             empty;
    logic             full;
    logic             pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0])
                && (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1]);

    // Latch may request while this is high
    assign room = !full;

    // Ack on an empty queue does nothing
    assign pop = ack && !empty;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_vector;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Outputs follow pointer state one edge later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending     <= 1'b0;
            head_vector <= '0;
        end else begin
            pending <= !empty;
            // Zero while empty so nothing stale is shown
            head_vector <= empty ? '0 : mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    // Latch only requests with room and keeps one lookup in flight
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("vector pushed into a full queue");

endmodule

`default_nettype wire

/* hw/irq_vector_unit.sv */
// Top level of the two-channel interrupt vector unit, wiring latches, arbiter, table and queues
`timescale 1ns/1ps
`default_nettype none

module irq_vector_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  irq_pkg::irq_mask_t      irq_a,
    input  irq_pkg::irq_mask_t      irq_b,
    input  wire                     ack_a,
    input  wire                     ack_b,
    input  wire                     cfg_we,
    input  table_pkg::table_index_t cfg_index,
    input  table_pkg::vector_t      cfg_vector,
    output table_pkg::vector_t      vector_a,
    output logic                    pending_a,
    output table_pkg::vector_t      vector_b,
    output logic                    pending_b
);
    import irq_pkg::*;
    import table_pkg::*;

    // Channel A lookup handshake
    logic    req_a;
    irq_id_t id_a;
    logic    grant_a;
    logic    done_a;
    logic    room_a;

    // Channel B lookup handshake
    logic    req_b;
    irq_id_t id_b;
    logic    grant_b;
    logic    done_b;
    logic    room_b;

    // Shared table read port
    logic         rd_en;
    table_index_t rd_index;
    vector_t      rd_vector;

    irq_latch latch_a (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq_a),
        .grant       (grant_a),
        .lookup_done (done_a),
        .room        (room_a),
        .lookup_req  (req_a),
        .lookup_id   (id_a)
    );

    irq_latch latch_b (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq_b),
        .grant       (grant_b),
        .lookup_done (done_b),
        .room        (room_b),
        .lookup_req  (req_b),
        .lookup_id   (id_b)
    );

    table_arbiter arbiter0 (
        .clk      (clk),
        .rst      (rst),
        .req_a    (req_a),
        .id_a     (id_a),
        .req_b    (req_b),
        .id_b     (id_b),
        .grant_a  (grant_a),
        .grant_b  (grant_b),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .done_a   (done_a),
        .done_b   (done_b)
    );

    vector_table table0 (
        .clk       (clk),
        .rst       (rst),
        .we        (cfg_we),
        .wr_index  (cfg_index),
        .wr_vector (cfg_vector),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_vector (rd_vector)
    );

    // Both queues see the same read data; done picks the owner
    vector_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue_a (
        .clk         (clk),
        .rst         (rst),
        .push        (done_a),
        .push_vector (rd_vector),
        .ack         (ack_a),
        .head_vector (vector_a),
        .pending     (pending_a),
        .room        (room_a)
    );

    vector_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue_b (
        .clk         (clk),
        .rst         (rst),
        .push        (done_b),
        .push_vector (rd_vector),
        .ack         (ack_b),
        .head_vector (vector_b),
        .pending     (pending_b),
        .room        (room_b)
    );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Clock and reset source for the testbench, 8 ns period with reset held for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        // Release on a falling edge, away from the flops
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

/* tb/tb_irq_vector_unit.sv */
// Testbench for the interrupt vector unit, applies a stimulus table and checks every vector
`timescale 1ns/1ps
`default_nettype none

module tb_irq_vector_unit;
    import irq_pkg::*;
    import table_pkg::*;

    localparam int NUM_FIXED = 8;
    localparam int NUM_ROWS = 12;
    localparam int PENDING_LIMIT = 40;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 400 + 100;

    typedef logic [3:0] row_t;

    logic clk;
    logic rst;
    irq_mask_t irq_a;
    irq_mask_t irq_b;
    logic ack_a;
    logic ack_b;
    logic cfg_we;
    table_index_t cfg_index;
    vector_t cfg_vector;
    vector_t vector_a;
    vector_t vector_b;
    logic pending_a;
    logic pending_b;

    // Stimulus table, one row per strobe cycle
    irq_mask_t row_irq_a [16];
    irq_mask_t row_irq_b [16];
    logic row_we [16];
    table_index_t row_index [16];
    vector_t row_vector [16];

    // Reference table and expected vectors per channel
    vector_t model [TABLE_ENTRIES];
    vector_t exp_vec [NUM_CHANNELS][NUM_SOURCES];
    int exp_count [NUM_CHANNELS];

    int error_count;
    int check_count;
    int cycle_count;
    integer seed;

    tb_clock_gen clock0 (
        .clk (clk),
        .rst (rst)
    );

    irq_vector_unit #(
        .QUEUE_DEPTH (4)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .irq_a      (irq_a),
        .irq_b      (irq_b),
        .ack_a      (ack_a),
        .ack_b      (ack_b),
        .cfg_we     (cfg_we),
        .cfg_index  (cfg_index),
        .cfg_vector (cfg_vector),
        .vector_a   (vector_a),
        .pending_a  (pending_a),
        .vector_b   (vector_b),
        .pending_b  (pending_b)
    );

    task automatic set_row(input int r, input irq_mask_t a, input irq_mask_t b,
                           input logic we, input table_index_t index, input vector_t vector);
        row_irq_a[row_t'(r)] = a;
        row_irq_b[row_t'(r)] = b;
        row_we[row_t'(r)] = we;
        row_index[row_t'(r)] = index;
        row_vector[row_t'(r)] = vector;
    endtask

    task automatic load_rows();
        // Single sources, then several bits, then both channels at once
        set_row(0, 8'h01, 8'h00, 1'b0, 4'h0, 32'h0);
        set_row(1, 8'h00, 8'h20, 1'b0, 4'h0, 32'h0);
        set_row(2, 8'h2c, 8'h00, 1'b0, 4'h0, 32'h0);
        set_row(3, 8'h81, 8'h42, 1'b0, 4'h0, 32'h0);
        // Rewritten entries, A source 3 and B source 1
        set_row(4, 8'h18, 8'h00, 1'b1, 4'h3, 32'hdead_bee0);
        set_row(5, 8'h08, 8'h06, 1'b1, 4'h9, 32'h4000_1230);
        // All ones overrun the 4-deep queue
        set_row(6, 8'hff, 8'h00, 1'b0, 4'h0, 32'h0);
        set_row(7, 8'hff, 8'hff, 1'b0, 4'h0, 32'h0);
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            set_row(r, irq_mask_t'($random(seed)), irq_mask_t'($random(seed)),
                    1'b0, 4'h0, 32'h0);
        end
    endtask

    // Set bits in ascending source order, entry is channel times 8 plus source
    task automatic build_expected(input irq_mask_t mask_a, input irq_mask_t mask_b);
        irq_mask_t mask;
        chan_t c;
        int n;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            c = chan_t'(ch);
            mask = (ch == 0) ? mask_a : mask_b;
            n = 0;
            for (int s = 0; s < NUM_SOURCES; s++) begin
                if (mask[irq_id_t'(s)]) begin
                    exp_vec[c][irq_id_t'(n)] = model[table_index_t'(ch * NUM_SOURCES + s)];
                    n++;
                end
            end
            exp_count[c] = n;
        end
    endtask

    // One-cycle strobes driven on the falling edge
    task automatic apply_row(input int r);
        row_t ri;
        ri = row_t'(r);
        if (row_we[ri]) begin
            model[row_index[ri]] = row_vector[ri];
        end
        build_expected(row_irq_a[ri], row_irq_b[ri]);
        irq_a = row_irq_a[ri];
        irq_b = row_irq_b[ri];
        cfg_we = row_we[ri];
        cfg_index = row_index[ri];
        cfg_vector = row_vector[ri];
        @(negedge clk);
        irq_a = '0;
        irq_b = '0;
        cfg_we = 1'b0;
    endtask

    task automatic drain_channel(input chan_t c);
        int waited;
        logic got_pending;
        vector_t got_vector;
        for (int k = 0; k < exp_count[c]; k++) begin
            waited = 0;
            got_pending = (c == 0) ? pending_a : pending_b;
            while (!got_pending && waited < PENDING_LIMIT) begin
                @(negedge clk);
                waited++;
                got_pending = (c == 0) ? pending_a : pending_b;
            end
            if (!got_pending) begin
                $display("Channel %0d never showed vector %0d of %0d", c, k, exp_count[c]);
                error_count++;
                break;
            end
            got_vector = (c == 0) ? vector_a : vector_b;
            check_count++;
            if (got_vector !== exp_vec[c][irq_id_t'(k)]) begin
                $display("[ERROR] %s expected %h got %h", (c == 0) ? "vector_a" : "vector_b",
                         exp_vec[c][irq_id_t'(k)], got_vector);
                error_count++;
            end
            if (c == 0) ack_a = 1'b1;
            else ack_b = 1'b1;
            @(negedge clk);
            ack_a = 1'b0;
            ack_b = 1'b0;
            // Pop shows on the outputs one edge after the ack
            repeat (2) @(negedge clk);
        end
        // Queue must be empty once the expected vectors are gone
        got_pending = (c == 0) ? pending_a : pending_b;
        check_count++;
        if (got_pending !== 1'b0) begin
            $display("[ERROR] %s expected %h got %h", (c == 0) ? "pending_a" : "pending_b",
                     1'b0, got_pending);
            error_count++;
        end
    endtask

    task automatic check_idle();
        check_count++;
        if (pending_a !== 1'b0 || pending_b !== 1'b0) begin
            $display("[ERROR] pending_a/pending_b expected 0/0 got %h/%h", pending_a, pending_b);
            error_count++;
        end
        check_count++;
        if (vector_a !== '0 || vector_b !== '0) begin
            $display("[ERROR] vector_a/vector_b expected 0/0 got %h/%h", vector_a, vector_b);
            error_count++;
        end
    endtask

    // Run limit scaled to the table length
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Something failed");
        $finish;
    end

    initial begin
        irq_a = '0;
        irq_b = '0;
        ack_a = 1'b0;
        ack_b = 1'b0;
        cfg_we = 1'b0;
        cfg_index = '0;
        cfg_vector = '0;
        error_count = 0;
        check_count = 0;
        seed = 32'ha4b4a409;
        // Reset layout: base plus index times 8
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            model[table_index_t'(i)] = VECTOR_BASE + vector_t'(i * 8);
        end
        load_rows();
        @(negedge rst);
        @(negedge clk);
        check_idle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
            drain_channel(chan_t'(0));
            drain_channel(chan_t'(1));
            // Both queues empty again, no late or stray vector on either side
            check_idle();
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/irq_pkg.sv
hw/table_pkg.sv
hw/irq_latch.sv
hw/table_arbiter.sv
hw/vector_table.sv
hw/vector_queue.sv
hw/irq_vector_unit.sv
tb/tb_clock_gen.sv
tb/tb_irq_vector_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_irq_vector_unit -f verilog.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
exit 1
